// File: include/exe_defines.svh
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// datapath widths
`define EXE_WORD_W       32
`define EXE_REG_ADDR_W   5
`define EXE_IMM_W        16
`define EXE_EXCODE_W     5
`define EXE_BYTE_EN_W    4

// exception codes
`define EXE_EXCODE_ADEL  5'd4
`define EXE_EXCODE_ADES  5'd5
`define EXE_EXCODE_OV    5'd12

// store byte enable patterns
`define EXE_BE_NONE      4'b0000
`define EXE_BE_WORD      4'b1111
`define EXE_BE_HALF_LO   4'b0011
`define EXE_BE_HALF_HI   4'b1100
// shifted left by the byte offset
`define EXE_BE_BYTE0     4'b0001

`endif

// File: source/exe_pkg.sv
`include "exe_defines.svh"

package exe_pkg;

    typedef logic [`EXE_WORD_W-1:0]     word_t;
    typedef logic [`EXE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`EXE_IMM_W-1:0]      imm_t;
    typedef logic [`EXE_EXCODE_W-1:0]   excode_t;
    typedef logic [`EXE_BYTE_EN_W-1:0]  byte_en_t;
    typedef logic [1:0]                 sram_size_t;

    // transfer size encodings on the data bus
    localparam sram_size_t sram_size_byte = 2'd0;
    localparam sram_size_t sram_size_half = 2'd1;
    localparam sram_size_t sram_size_word = 2'd2;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [2:0] {
        mem_none, mem_load_word, mem_load_half, mem_load_byte,
        mem_store_word, mem_store_half, mem_store_byte
    } mem_op_t;

endpackage

// File: source/exe_stage_reg.sv
`timescale 1ns/1ps

module exe_stage_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                ds_valid,
    input  exe_pkg::alu_op_t    ds_alu_op,
    input  exe_pkg::mem_op_t    ds_mem_op,
    input  logic                ds_signed,
    input  logic                ds_src2_is_imm,
    input  logic                ds_imm_signed,
    input  exe_pkg::word_t      ds_rs_value,
    input  exe_pkg::word_t      ds_rt_value,
    input  exe_pkg::imm_t       ds_imm,
    input  exe_pkg::reg_addr_t  ds_dest,
    input  exe_pkg::word_t      ds_pc,
    input  logic                ds_ex,
    input  exe_pkg::excode_t    ds_excode,
    input  logic                ready_go,
    input  logic                ms_allowin,
    output logic                ds_allowin,
    output logic                valid,
    output exe_pkg::alu_op_t    alu_op,
    output exe_pkg::mem_op_t    mem_op,
    output logic                signed_op,
    output logic                src2_is_imm,
    output logic                imm_signed,
    output exe_pkg::word_t      rs_value,
    output exe_pkg::word_t      rt_value,
    output exe_pkg::imm_t       imm,
    output exe_pkg::reg_addr_t  dest,
    output exe_pkg::word_t      pc,
    output logic                ex_in,
    output exe_pkg::excode_t    excode_in
);

    // empty, or the held instruction moves on this cycle
    assign ds_allowin = !valid || (ready_go && ms_allowin);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (ds_allowin) begin
            valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_valid && ds_allowin) begin
            alu_op      <= ds_alu_op;
            mem_op      <= ds_mem_op;
            signed_op   <= ds_signed;
            src2_is_imm <= ds_src2_is_imm;
            imm_signed  <= ds_imm_signed;
            rs_value    <= ds_rs_value;
            rt_value    <= ds_rt_value;
            imm         <= ds_imm;
            dest        <= ds_dest;
            pc          <= ds_pc;
            ex_in       <= ds_ex;
            excode_in   <= ds_excode;
        end
    end

endmodule

// File: source/exe_alu.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_alu (
    input  exe_pkg::alu_op_t  alu_op,
    input  logic              signed_op,
    input  logic              src2_is_imm,
    input  logic              imm_signed,
    input  exe_pkg::word_t    rs_value,
    input  exe_pkg::word_t    rt_value,
    input  exe_pkg::imm_t     imm,
    output exe_pkg::word_t    alu_result,
    output logic              overflow
);

    localparam int shamt_w = $clog2(`EXE_WORD_W);
    localparam int ext_w   = `EXE_WORD_W - `EXE_IMM_W;

    exe_pkg::word_t     src1;
    exe_pkg::word_t     src2;
    exe_pkg::word_t     imm_ext;
    exe_pkg::word_t     sum;
    exe_pkg::word_t     diff;
    logic [shamt_w-1:0] shamt;
    logic               add_ovf;
    logic               sub_ovf;

    assign imm_ext = imm_signed ? {{ext_w{imm[`EXE_IMM_W-1]}}, imm}
                                : {{ext_w{1'b0}}, imm};

    assign src1  = rs_value;
    assign src2  = src2_is_imm ? imm_ext : rt_value;
    assign shamt = src1[shamt_w-1:0];

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // signed overflow from the operand and result sign bits
    assign add_ovf = (src1[`EXE_WORD_W-1] == src2[`EXE_WORD_W-1])
                  && (sum[`EXE_WORD_W-1] != src1[`EXE_WORD_W-1]);
    assign sub_ovf = (src1[`EXE_WORD_W-1] != src2[`EXE_WORD_W-1])
                  && (diff[`EXE_WORD_W-1] != src1[`EXE_WORD_W-1]);

    always_comb begin
        case (alu_op)
            exe_pkg::alu_add:  alu_result = sum;
            exe_pkg::alu_sub:  alu_result = diff;
            exe_pkg::alu_slt:  alu_result = {{(`EXE_WORD_W-1){1'b0}},
                                             $signed(src1) < $signed(src2)};
            exe_pkg::alu_sltu: alu_result = {{(`EXE_WORD_W-1){1'b0}}, src1 < src2};
            exe_pkg::alu_and:  alu_result = src1 & src2;
            exe_pkg::alu_or:   alu_result = src1 | src2;
            exe_pkg::alu_xor:  alu_result = src1 ^ src2;
            exe_pkg::alu_nor:  alu_result = ~(src1 | src2);
            exe_pkg::alu_sll:  alu_result = src2 << shamt;
            exe_pkg::alu_srl:  alu_result = src2 >> shamt;
            exe_pkg::alu_sra:  alu_result = $signed(src2) >>> shamt;
            exe_pkg::alu_lui:  alu_result = {imm, {ext_w{1'b0}}};
            default:           alu_result = sum;
        endcase
    end

    // unsigned add and sub never trap
    always_comb begin
        overflow = 1'b0;
        if (signed_op) begin
            if (alu_op == exe_pkg::alu_add) begin
                overflow = add_ovf;
            end else if (alu_op == exe_pkg::alu_sub) begin
                overflow = sub_ovf;
            end
        end
    end

endmodule

// File: source/exe_mem_request.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_mem_request (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  valid,
    input  exe_pkg::mem_op_t      mem_op,
    input  exe_pkg::word_t        alu_result,
    input  logic                  overflow,
    input  exe_pkg::word_t        rt_value,
    input  exe_pkg::reg_addr_t    dest,
    input  exe_pkg::word_t        pc,
    input  logic                  ex_in,
    input  exe_pkg::excode_t      excode_in,
    input  logic                  ms_allowin,
    input  logic                  data_sram_addr_ok,
    output logic                  ready_go,
    output logic                  ms_valid,
    output exe_pkg::word_t        ms_alu_result,
    output exe_pkg::reg_addr_t    ms_dest,
    output exe_pkg::mem_op_t      ms_mem_op,
    output exe_pkg::word_t        ms_pc,
    output logic                  ms_ex,
    output exe_pkg::excode_t      ms_excode,
    output logic                  data_sram_en,
    output exe_pkg::byte_en_t     data_sram_wen,
    output exe_pkg::sram_size_t   data_sram_size,
    output exe_pkg::word_t        data_sram_addr,
    output exe_pkg::word_t        data_sram_wdata
);

    logic               is_load;
    logic               is_store;
    logic               misaligned;
    logic               accepted;
    logic               addr_ok_r;
    logic               leave;
    exe_pkg::byte_en_t  store_be;

    assign is_load  = mem_op inside {exe_pkg::mem_load_word, exe_pkg::mem_load_half,
                                     exe_pkg::mem_load_byte};
    assign is_store = mem_op inside {exe_pkg::mem_store_word, exe_pkg::mem_store_half,
                                     exe_pkg::mem_store_byte};

    // byte accesses are always aligned
    assign misaligned = ((mem_op == exe_pkg::mem_load_word
                          || mem_op == exe_pkg::mem_store_word) && |alu_result[1:0])
                     || ((mem_op == exe_pkg::mem_load_half
                          || mem_op == exe_pkg::mem_store_half) && alu_result[0]);

    always_comb begin
        ms_ex     = 1'b1;
        ms_excode = excode_in;
        if (ex_in) begin
            ms_excode = excode_in;
        end else if (is_load && misaligned) begin
            ms_excode = `EXE_EXCODE_ADEL;
        end else if (is_store && misaligned) begin
            ms_excode = `EXE_EXCODE_ADES;
        end else if (overflow) begin
            ms_excode = `EXE_EXCODE_OV;
        end else begin
            ms_ex     = 1'b0;
            ms_excode = '0;
        end
    end

    assign data_sram_en = valid && (is_load || is_store) && !ms_ex && !flush && !addr_ok_r;
    assign accepted     = data_sram_en && data_sram_addr_ok;

    assign ready_go = !(is_load || is_store) || ms_ex || accepted || addr_ok_r;
    assign ms_valid = valid && ready_go && !flush;
    assign leave    = ms_valid && ms_allowin;

    // address taken but memory stage not ready yet
    always_ff @(posedge clk) begin
        if (reset || flush || leave) begin
            addr_ok_r <= 1'b0;
        end else if (accepted) begin
            addr_ok_r <= 1'b1;
        end
    end

    always_comb begin
        data_sram_size  = exe_pkg::sram_size_word;
        store_be        = `EXE_BE_NONE;
        data_sram_wdata = rt_value;
        case (mem_op)
            exe_pkg::mem_load_half: data_sram_size = exe_pkg::sram_size_half;
            exe_pkg::mem_load_byte: data_sram_size = exe_pkg::sram_size_byte;
            exe_pkg::mem_store_word: store_be = `EXE_BE_WORD;
            exe_pkg::mem_store_half: begin
                data_sram_size  = exe_pkg::sram_size_half;
                store_be        = alu_result[1] ? `EXE_BE_HALF_HI : `EXE_BE_HALF_LO;
                data_sram_wdata = {2{rt_value[15:0]}};
            end
            exe_pkg::mem_store_byte: begin
                data_sram_size  = exe_pkg::sram_size_byte;
                store_be        = `EXE_BE_BYTE0 << alu_result[1:0];
                data_sram_wdata = {4{rt_value[7:0]}};
            end
            default: ;
        endcase
    end

    // no write strobes unless a request is actually going out
    assign data_sram_wen  = data_sram_en ? store_be : `EXE_BE_NONE;
    assign data_sram_addr = alu_result;

    assign ms_alu_result = alu_result;
    assign ms_dest       = dest;
    assign ms_mem_op     = mem_op;
    assign ms_pc         = pc;

endmodule

// File: source/exe_core.sv
`timescale 1ns/1ps

module exe_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  ds_valid,
    input  exe_pkg::alu_op_t      ds_alu_op,
    input  exe_pkg::mem_op_t      ds_mem_op,
    input  logic                  ds_signed,
    input  logic                  ds_src2_is_imm,
    input  logic                  ds_imm_signed,
    input  exe_pkg::word_t        ds_rs_value,
    input  exe_pkg::word_t        ds_rt_value,
    input  exe_pkg::imm_t         ds_imm,
    input  exe_pkg::reg_addr_t    ds_dest,
    input  exe_pkg::word_t        ds_pc,
    input  logic                  ds_ex,
    input  exe_pkg::excode_t      ds_excode,
    output logic                  ds_allowin,
    output logic                  ms_valid,
    output exe_pkg::word_t        ms_alu_result,
    output exe_pkg::reg_addr_t    ms_dest,
    output exe_pkg::mem_op_t      ms_mem_op,
    output exe_pkg::word_t        ms_pc,
    output logic                  ms_ex,
    output exe_pkg::excode_t      ms_excode,
    input  logic                  ms_allowin,
    output logic                  data_sram_en,
    output exe_pkg::byte_en_t     data_sram_wen,
    output exe_pkg::sram_size_t   data_sram_size,
    output exe_pkg::word_t        data_sram_addr,
    output exe_pkg::word_t        data_sram_wdata,
    input  logic                  data_sram_addr_ok
);

    logic                valid;
    logic                ready_go;
    exe_pkg::alu_op_t    alu_op;
    exe_pkg::mem_op_t    mem_op;
    logic                signed_op;
    logic                src2_is_imm;
    logic                imm_signed;
    exe_pkg::word_t      rs_value;
    exe_pkg::word_t      rt_value;
    exe_pkg::imm_t       imm;
    exe_pkg::reg_addr_t  dest;
    exe_pkg::word_t      pc;
    logic                ex_in;
    exe_pkg::excode_t    excode_in;
    exe_pkg::word_t      alu_result;
    logic                overflow;

    exe_stage_reg i_exe_stage_reg (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .ds_valid       (ds_valid),
        .ds_alu_op      (ds_alu_op),
        .ds_mem_op      (ds_mem_op),
        .ds_signed      (ds_signed),
        .ds_src2_is_imm (ds_src2_is_imm),
        .ds_imm_signed  (ds_imm_signed),
        .ds_rs_value    (ds_rs_value),
        .ds_rt_value    (ds_rt_value),
        .ds_imm         (ds_imm),
        .ds_dest        (ds_dest),
        .ds_pc          (ds_pc),
        .ds_ex          (ds_ex),
        .ds_excode      (ds_excode),
        .ready_go       (ready_go),
        .ms_allowin     (ms_allowin),
        .ds_allowin     (ds_allowin),
        .valid          (valid),
        .alu_op         (alu_op),
        .mem_op         (mem_op),
        .signed_op      (signed_op),
        .src2_is_imm    (src2_is_imm),
        .imm_signed     (imm_signed),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .imm            (imm),
        .dest           (dest),
        .pc             (pc),
        .ex_in          (ex_in),
        .excode_in      (excode_in)
    );

    exe_alu i_exe_alu (
        .alu_op      (alu_op),
        .signed_op   (signed_op),
        .src2_is_imm (src2_is_imm),
        .imm_signed  (imm_signed),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .imm         (imm),
        .alu_result  (alu_result),
        .overflow    (overflow)
    );

    exe_mem_request i_exe_mem_request (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .valid             (valid),
        .mem_op            (mem_op),
        .alu_result        (alu_result),
        .overflow          (overflow),
        .rt_value          (rt_value),
        .dest              (dest),
        .pc                (pc),
        .ex_in             (ex_in),
        .excode_in         (excode_in),
        .ms_allowin        (ms_allowin),
        .data_sram_addr_ok (data_sram_addr_ok),
        .ready_go          (ready_go),
        .ms_valid          (ms_valid),
        .ms_alu_result     (ms_alu_result),
        .ms_dest           (ms_dest),
        .ms_mem_op         (ms_mem_op),
        .ms_pc             (ms_pc),
        .ms_ex             (ms_ex),
        .ms_excode         (ms_excode),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_size    (data_sram_size),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata)
    );

endmodule

// File: verif/exe_core_clock_gen.sv
`timescale 1ns/1ps

module exe_core_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // released on a falling edge like the other inputs
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: verif/exe_core_tb.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_core_tb;

    localparam int num_instr      = 400;
    localparam int timeout_cycles = num_instr * 12;

    typedef struct packed {
        exe_pkg::word_t      pc;
        exe_pkg::word_t      result;
        exe_pkg::reg_addr_t  dest;
        exe_pkg::mem_op_t    mop;
        logic                ex;
        exe_pkg::excode_t    excode;
        logic                is_mem;
        exe_pkg::sram_size_t size;
        exe_pkg::byte_en_t   wen;
        exe_pkg::word_t      wdata;
    } expect_t;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    logic                  ds_valid;
    exe_pkg::alu_op_t      ds_alu_op;
    exe_pkg::mem_op_t      ds_mem_op;
    logic                  ds_signed;
    logic                  ds_src2_is_imm;
    logic                  ds_imm_signed;
    exe_pkg::word_t        ds_rs_value;
    exe_pkg::word_t        ds_rt_value;
    exe_pkg::imm_t         ds_imm;
    exe_pkg::reg_addr_t    ds_dest;
    exe_pkg::word_t        ds_pc;
    logic                  ds_ex;
    exe_pkg::excode_t      ds_excode;
    logic                  ds_allowin;
    logic                  ms_valid;
    exe_pkg::word_t        ms_alu_result;
    exe_pkg::reg_addr_t    ms_dest;
    exe_pkg::mem_op_t      ms_mem_op;
    exe_pkg::word_t        ms_pc;
    logic                  ms_ex;
    exe_pkg::excode_t      ms_excode;
    logic                  ms_allowin;
    logic                  data_sram_en;
    exe_pkg::byte_en_t     data_sram_wen;
    exe_pkg::sram_size_t   data_sram_size;
    exe_pkg::word_t        data_sram_addr;
    exe_pkg::word_t        data_sram_wdata;
    logic                  data_sram_addr_ok;

    expect_t     expect_q[$];
    int          accepted_count = 0;
    int          head_reqs      = 0;
    int          fail_count     = 0;
    int          cycle_count    = 0;
    int          ok_delay       = 0;
    int unsigned seed_discard;
    logic        ds_done = 1'b1;
    logic        last_en = 1'b0;
    logic        last_ok = 1'b0;
    logic        held    = 1'b0;

    exe_core_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    exe_core i_exe_core (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .ds_valid          (ds_valid),
        .ds_alu_op         (ds_alu_op),
        .ds_mem_op         (ds_mem_op),
        .ds_signed         (ds_signed),
        .ds_src2_is_imm    (ds_src2_is_imm),
        .ds_imm_signed     (ds_imm_signed),
        .ds_rs_value       (ds_rs_value),
        .ds_rt_value       (ds_rt_value),
        .ds_imm            (ds_imm),
        .ds_dest           (ds_dest),
        .ds_pc             (ds_pc),
        .ds_ex             (ds_ex),
        .ds_excode         (ds_excode),
        .ds_allowin        (ds_allowin),
        .ms_valid          (ms_valid),
        .ms_alu_result     (ms_alu_result),
        .ms_dest           (ms_dest),
        .ms_mem_op         (ms_mem_op),
        .ms_pc             (ms_pc),
        .ms_ex             (ms_ex),
        .ms_excode         (ms_excode),
        .ms_allowin        (ms_allowin),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_size    (data_sram_size),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_addr_ok (data_sram_addr_ok)
    );

    task automatic fail_run(input string what);
        fail_count++;
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_word(input string name, input exe_pkg::word_t exp,
                                input exe_pkg::word_t act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_excode(input string name, input exe_pkg::excode_t exp,
                                  input exe_pkg::excode_t act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_byte_en(input string name, input exe_pkg::byte_en_t exp,
                                   input exe_pkg::byte_en_t act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic compare_size(input string name, input exe_pkg::sram_size_t exp,
                                input exe_pkg::sram_size_t act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_reg_addr(input string name, input exe_pkg::reg_addr_t exp,
                                    input exe_pkg::reg_addr_t act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_mem_op(input string name, input exe_pkg::mem_op_t exp,
                                  input exe_pkg::mem_op_t act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic expect_t reference_model(
        input exe_pkg::alu_op_t   op,
        input exe_pkg::mem_op_t   mop,
        input logic               sgn,
        input logic               use_imm,
        input logic               imm_sext,
        input exe_pkg::word_t     a,
        input exe_pkg::word_t     rt,
        input exe_pkg::imm_t      imm,
        input exe_pkg::word_t     pc,
        input exe_pkg::reg_addr_t dest,
        input logic               ex_in,
        input exe_pkg::excode_t   code_in
    );
        expect_t        e;
        exe_pkg::word_t b;
        logic [32:0]    wide;
        logic           ovf;
        logic           is_load;
        logic           is_store;
        logic           mis;
        b    = use_imm ? (imm_sext ? {{16{imm[15]}}, imm} : {16'h0000, imm}) : rt;
        ovf  = 1'b0;
        wide = '0;
        case (op)
            exe_pkg::alu_add: begin
                // one extra sign bit exposes signed overflow
                wide     = {a[31], a} + {b[31], b};
                ovf      = wide[32] ^ wide[31];
                e.result = wide[31:0];
            end
            exe_pkg::alu_sub: begin
                wide     = {a[31], a} - {b[31], b};
                ovf      = wide[32] ^ wide[31];
                e.result = wide[31:0];
            end
            exe_pkg::alu_slt:  e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exe_pkg::alu_sltu: e.result = (a < b) ? 32'd1 : 32'd0;
            exe_pkg::alu_and:  e.result = a & b;
            exe_pkg::alu_or:   e.result = a | b;
            exe_pkg::alu_xor:  e.result = a ^ b;
            exe_pkg::alu_nor:  e.result = ~(a | b);
            exe_pkg::alu_sll:  e.result = b << a[4:0];
            exe_pkg::alu_srl:  e.result = b >> a[4:0];
            exe_pkg::alu_sra:  e.result = $signed(b) >>> a[4:0];
            exe_pkg::alu_lui:  e.result = {imm, 16'h0000};
            default:           e.result = '0;
        endcase
        is_load  = (mop == exe_pkg::mem_load_word) || (mop == exe_pkg::mem_load_half)
                || (mop == exe_pkg::mem_load_byte);
        is_store = (mop == exe_pkg::mem_store_word) || (mop == exe_pkg::mem_store_half)
                || (mop == exe_pkg::mem_store_byte);
        case (mop)
            exe_pkg::mem_load_word, exe_pkg::mem_store_word: begin
                e.size = exe_pkg::sram_size_word;
                mis    = (e.result[1:0] != 2'b00);
            end
            exe_pkg::mem_load_half, exe_pkg::mem_store_half: begin
                e.size = exe_pkg::sram_size_half;
                mis    = e.result[0];
            end
            default: begin
                e.size = exe_pkg::sram_size_byte;
                mis    = 1'b0;
            end
        endcase
        e.wdata = rt;
        case (mop)
            exe_pkg::mem_store_word: e.wen = 4'b1111;
            exe_pkg::mem_store_half: begin
                e.wen   = e.result[1] ? 4'b1100 : 4'b0011;
                e.wdata = {2{rt[15:0]}};
            end
            exe_pkg::mem_store_byte: begin
                e.wen   = 4'b0001 << e.result[1:0];
                e.wdata = {4{rt[7:0]}};
            end
            default: e.wen = 4'b0000;
        endcase
        e.pc     = pc;
        e.dest   = dest;
        e.mop    = mop;
        e.is_mem = is_load || is_store;
        e.ex     = 1'b1;
        if (ex_in) begin
            e.excode = code_in;
        end else if (is_load && mis) begin
            e.excode = `EXE_EXCODE_ADEL;
        end else if (is_store && mis) begin
            e.excode = `EXE_EXCODE_ADES;
        end else if (ovf && sgn) begin
            e.excode = `EXE_EXCODE_OV;
        end else begin
            e.ex     = 1'b0;
            e.excode = '0;
        end
        return e;
    endfunction

    function automatic exe_pkg::word_t pick_operand();
        case ($urandom_range(7))
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'h7fff_ffff;
            3: return 32'h8000_0000;
            4: return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic exe_pkg::imm_t pick_imm();
        case ($urandom_range(5))
            0: return 16'h0000;
            1: return 16'h7fff;
            2: return 16'h8000;
            3: return 16'hffff;
            default: return 16'($urandom);
        endcase
    endfunction

    task automatic new_instruction();
        exe_pkg::word_t addr;
        ds_valid    = ($urandom_range(4) != 0);
        ds_pc       = ds_pc + 32'd4;
        ds_dest     = 5'($urandom);
        ds_ex       = ($urandom_range(15) == 0);
        ds_excode   = 5'($urandom);
        ds_rt_value = pick_operand();
        ds_imm      = pick_imm();
        if ($urandom_range(1) == 0) begin
            // base plus signed offset, aligned half the time
            addr = $urandom;
            if ($urandom_range(1) == 0) begin
                addr[1:0] = 2'b00;
            end
            ds_mem_op      = exe_pkg::mem_op_t'($urandom_range(6, 1));
            ds_alu_op      = exe_pkg::alu_add;
            ds_signed      = ($urandom_range(3) == 0);
            ds_src2_is_imm = 1'b1;
            ds_imm_signed  = 1'b1;
            ds_rs_value    = addr - {{16{ds_imm[15]}}, ds_imm};
        end else begin
            ds_mem_op      = exe_pkg::mem_none;
            ds_alu_op      = exe_pkg::alu_op_t'($urandom_range(11));
            ds_signed      = ($urandom_range(1) == 0);
            ds_src2_is_imm = ($urandom_range(1) == 0);
            ds_imm_signed  = ($urandom_range(1) == 0);
            ds_rs_value    = pick_operand();
        end
    endtask

    // one sample per cycle, well after the falling edge drive
    task automatic check_cycle();
        expect_t head;
        string   tname;
        logic    req_ok;
        logic    exp_valid;
        req_ok = data_sram_en && data_sram_addr_ok;
        if (flush) begin
            compare_flag("ms_valid during flush", 1'b0, ms_valid);
            compare_flag("data_sram_en during flush", 1'b0, data_sram_en);
            expect_q.delete();
            head_reqs = 0;
        end else if (expect_q.size() == 0) begin
            compare_flag("ms_valid with empty stage", 1'b0, ms_valid);
            compare_flag("data_sram_en with empty stage", 1'b0, data_sram_en);
            compare_flag("ds_allowin with empty stage", 1'b1, ds_allowin);
        end else begin
            head  = expect_q[0];
            tname = $sformatf("pc %h", head.pc);
            if (held) begin
                compare_flag({tname, " ms_valid while held"}, 1'b1, ms_valid);
            end
            if (!head.is_mem || head.ex) begin
                compare_flag({tname, " data_sram_en"}, 1'b0, data_sram_en);
            end else if (data_sram_en) begin
                if (head_reqs != 0) begin
                    fail_run({tname, " issued a request after its address was accepted"});
                end
                compare_word({tname, " data_sram_addr"}, head.result, data_sram_addr);
                compare_size({tname, " data_sram_size"}, head.size, data_sram_size);
                compare_byte_en({tname, " data_sram_wen"}, head.wen, data_sram_wen);
                // loads carry no write data
                if (head.wen != 4'b0000) begin
                    compare_word({tname, " data_sram_wdata"}, head.wdata, data_sram_wdata);
                end
            end
            if (req_ok) begin
                head_reqs++;
            end
            // memory access goes on in the cycle its address is taken
            exp_valid = !head.is_mem || head.ex || (head_reqs != 0);
            compare_flag({tname, " ms_valid"}, exp_valid, ms_valid);
            compare_flag({tname, " ds_allowin"}, exp_valid && ms_allowin, ds_allowin);
            if (ms_valid) begin
                compare_word({tname, " ms_pc"}, head.pc, ms_pc);
                compare_word({tname, " ms_alu_result"}, head.result, ms_alu_result);
                compare_reg_addr({tname, " ms_dest"}, head.dest, ms_dest);
                compare_mem_op({tname, " ms_mem_op"}, head.mop, ms_mem_op);
                compare_flag({tname, " ms_ex"}, head.ex, ms_ex);
                compare_excode({tname, " ms_excode"}, head.excode, ms_excode);
                if (ms_allowin) begin
                    head      = expect_q.pop_front();
                    head_reqs = 0;
                end
            end
        end
        if (!data_sram_en) begin
            compare_byte_en("data_sram_wen without request", 4'b0000, data_sram_wen);
        end
        held = ms_valid && !ms_allowin;
        if (!flush && ds_valid && ds_allowin) begin
            expect_q.push_back(reference_model(ds_alu_op, ds_mem_op, ds_signed, ds_src2_is_imm,
                                               ds_imm_signed, ds_rs_value, ds_rt_value, ds_imm,
                                               ds_pc, ds_dest, ds_ex, ds_excode));
            accepted_count++;
        end
        ds_done = !ds_valid || ds_allowin || flush;
        last_en = data_sram_en;
        last_ok = req_ok;
    endtask

    initial begin
        seed_discard      = $urandom(32'h2df9_2023);
        flush             = 1'b0;
        ds_valid          = 1'b0;
        ds_alu_op         = exe_pkg::alu_add;
        ds_mem_op         = exe_pkg::mem_none;
        ds_signed         = 1'b0;
        ds_src2_is_imm    = 1'b0;
        ds_imm_signed     = 1'b0;
        ds_rs_value       = '0;
        ds_rt_value       = '0;
        ds_imm            = '0;
        ds_dest           = '0;
        ds_pc             = 32'h0040_0000;
        ds_ex             = 1'b0;
        ds_excode         = '0;
        ms_allowin        = 1'b1;
        data_sram_addr_ok = 1'b0;
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (accepted_count >= num_instr) begin
                ds_valid = 1'b0;
            end else if (ds_done) begin
                new_instruction();
            end
            ms_allowin = ($urandom_range(2) != 0);
            flush      = ($urandom_range(39) == 0);
            // memory answers 0 to 3 cycles into a request
            if (last_ok) begin
                ok_delay = $urandom_range(3);
            end else if (last_en && ok_delay > 0) begin
                ok_delay--;
            end
            data_sram_addr_ok = (ok_delay == 0);
        end
    end

    initial begin
        @(negedge reset);
        forever begin
            @(negedge clk);
            #10;
            check_cycle();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            fail_run($sformatf("timeout after %0d cycles with %0d of %0d instructions accepted",
                               cycle_count, accepted_count, num_instr));
        end
    end

    initial begin
        @(negedge reset);
        while (accepted_count < num_instr || expect_q.size() != 0) begin
            @(negedge clk);
        end
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: exe_core.f
+incdir+include
source/exe_pkg.sv
source/exe_stage_reg.sv
source/exe_alu.sv
source/exe_mem_request.sv
source/exe_core.sv
verif/exe_core_clock_gen.sv
verif/exe_core_tb.sv
